// File: Bender.yml
package:
  name: game_core

sources:
  - include_dirs:
      - source
    files:
      - source/tile_pkg.sv
      - source/player_pkg.sv
      - source/map_port_if.sv
      - source/move_arbiter.sv
      - source/player_ctrl.sv
      - source/map_ram.sv
      - source/map_renderer.sv
      - source/game_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_game_core.sv

// File: source/game_core.sv
`timescale 1ns/1ps
`default_nettype none

module game_core (
  input  logic        clk,
  input  logic        rst,
  input  logic [3:0]  keys,
  input  logic        frame_start,
  output logic [1:0]  floor,
  output logic [3:0]  player_x,
  output logic [3:0]  player_y,
  output logic [3:0]  key_num,
  output logic [15:0] health,
  output logic [7:0]  dst_addr,
  output logic [15:0] dst_data,
  output logic        dst_wr,
  output logic        frame_done
);
  import player_pkg::*;

  logic           move;
  dir_e           dir;
  player_status_s status;

  // port a for the renderer, port b for the player
  map_port_if map_a ();
  map_port_if map_b ();

  move_arbiter u_move_arbiter (
    .clk  (clk),
    .rst  (rst),
    .keys (keys),
    .move (move),
    .dir  (dir)
  );

  player_ctrl u_player_ctrl (
    .clk    (clk),
    .rst    (rst),
    .move   (move),
    .dir    (dir),
    .map    (map_b),
    .status (status)
  );

  map_ram u_map_ram (
    .clk    (clk),
    .port_a (map_a),
    .port_b (map_b)
  );

  map_renderer u_map_renderer (
    .clk         (clk),
    .rst         (rst),
    .frame_start (frame_start),
    .status      (status),
    .map         (map_a),
    .dst_addr    (dst_addr),
    .dst_data    (dst_data),
    .dst_wr      (dst_wr),
    .frame_done  (frame_done)
  );

  assign floor    = status.floor;
  assign player_x = status.x;
  assign player_y = status.y;
  assign key_num  = status.key_num;
  assign health   = status.health;

endmodule

`default_nettype wire

// File: source/game_macros.svh
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// map geometry
`define MAP_DIM 16
`define FLOORS 4

// clock cycles per logic tick
`define TICK_DIV 4

`define START_HEALTH 100

// sprite code drawn over the player's tile
`define PLAYER_SPRITE 8'hF0

`endif

// File: source/map_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface map_port_if;
  import tile_pkg::*;

  map_addr_t  addr;
  tile_word_u rdata;
  tile_word_u wdata;
  logic       wr;

  modport master (output addr, output wdata, output wr, input rdata);

  modport ram (input addr, input wdata, input wr, output rdata);

endinterface

`default_nettype wire

// File: source/map_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_macros.svh"

module map_ram (
  input logic     clk,
  map_port_if.ram port_a,
  map_port_if.ram port_b
);
  import tile_pkg::*;

  localparam int DEPTH = `FLOORS * `MAP_DIM * `MAP_DIM;

  tile_word_u mem [DEPTH];

  // level layout for floor f, column x, row y
  function automatic tile_word_u level_tile(input int f, input int x, input int y);
    tile_word_u t;
    t          = '0;
    t.obj.kind = EMPTY;
    if (x == 0 || y == 0 || x == `MAP_DIM - 1 || y == `MAP_DIM - 1) begin
      t.obj.kind = WALL;
    end else if (x == `MAP_DIM / 2) begin
      t.obj.kind = (y == `MAP_DIM / 2) ? DOOR : WALL;
    end else if (x == 2 * f + 3 && y == 2) begin
      t.obj.kind = KEY;
    end else if (x == 4 && y == 4 + f) begin
      t.obj.kind  = MONSTER;
      t.obj.value = 12'(10 + f);
    end else if (x == `MAP_DIM - 2 && y == `MAP_DIM - 2) begin
      t.obj.kind = STAIRS;
    end
    return t;
  endfunction

  initial begin
    for (int f = 0; f < `FLOORS; f++) begin
      for (int y = 0; y < `MAP_DIM; y++) begin
        for (int x = 0; x < `MAP_DIM; x++) begin
          mem[(f * `MAP_DIM + y) * `MAP_DIM + x] = level_tile(f, x, y);
        end
      end
    end
  end

  // port a is read only
  always_ff @(posedge clk) begin
    port_a.rdata <= mem[port_a.addr];
  end

  // read before write on port b
  always @(posedge clk) begin
    if (port_b.wr) begin
      mem[port_b.addr] <= port_b.wdata;
    end
    port_b.rdata <= mem[port_b.addr];
  end

endmodule

`default_nettype wire

// File: source/map_renderer.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_macros.svh"

module map_renderer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       frame_start,
  input  player_pkg::player_status_s status,
  map_port_if.master                 map,
  output logic [7:0]                 dst_addr,
  output logic [15:0]                dst_data,
  output logic                       dst_wr,
  output logic                       frame_done
);
  import tile_pkg::*;
  import player_pkg::*;

  localparam logic [7:0] LAST_TILE = 8'(`MAP_DIM * `MAP_DIM - 1);

  logic           active;
  logic           start;
  logic [7:0]     rd_cnt;
  logic           wr_q;
  logic [7:0]     wr_addr_q;
  player_status_s snap;
  tile_word_u     word;

  // frame_start is ignored while reads or writes are pending
  assign start = frame_start && !active && !wr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      rd_cnt <= 8'd0;
      wr_q   <= 1'b0;
    end else begin
      wr_q <= active;
      if (active) begin
        rd_cnt <= rd_cnt + 8'd1;
        if (rd_cnt == LAST_TILE) begin
          active <= 1'b0;
        end
      end else if (start) begin
        active <= 1'b1;
        rd_cnt <= 8'd0;
      end
    end
  end

  // floor and player position frozen for the whole frame
  always_ff @(posedge clk) begin
    wr_addr_q <= rd_cnt;
    if (start) begin
      snap <= status;
    end
  end

  assign map.addr  = {snap.floor, rd_cnt};
  assign map.wr    = 1'b0;
  assign map.wdata = '0;

  // player sprite over its tile, palette kept
  always_comb begin
    word = map.rdata;
    if (wr_addr_q == {snap.y, snap.x}) begin
      word.gfx.sprite = `PLAYER_SPRITE;
    end
  end

  assign dst_wr     = wr_q;
  assign dst_addr   = wr_addr_q;
  assign dst_data   = word;
  assign frame_done = wr_q && (wr_addr_q == LAST_TILE);

endmodule

`default_nettype wire

// File: source/move_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_macros.svh"

module move_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  logic [3:0]       keys,
  output logic             move,
  output player_pkg::dir_e dir
);
  import player_pkg::*;

  localparam int CNT_W = (`TICK_DIV > 1) ? $clog2(`TICK_DIV) : 1;

  logic [CNT_W-1:0] tick_cnt;
  logic             tick;
  logic [3:0]       keys_q;
  logic [3:0]       rise;

  assign tick = (tick_cnt == CNT_W'(`TICK_DIV - 1));
  // keys is {right, up, down, left}
  assign rise = keys & ~keys_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      keys_q <= '0;
      move   <= 1'b0;
      dir    <= UP;
    end else begin
      move <= tick && (rise != 4'b0000);
      if (tick) begin
        keys_q <= keys;
        // fixed priority up, down, left, right
        if (rise[2]) begin
          dir <= UP;
        end else if (rise[1]) begin
          dir <= DOWN;
        end else if (rise[0]) begin
          dir <= LEFT;
        end else if (rise[3]) begin
          dir <= RIGHT;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/player_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_macros.svh"

module player_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       move,
  input  player_pkg::dir_e           dir,
  map_port_if.master                 map,
  output player_pkg::player_status_s status
);
  import tile_pkg::*;
  import player_pkg::*;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_READ = 2'd1;
  localparam logic [1:0] S_EVAL = 2'd2;

  logic [1:0]     state;
  map_addr_t      tgt;
  map_addr_t      step_tgt;
  tile_word_u     tile;
  player_status_s next_status;
  logic           step;
  logic           consume;

  // neighbour in the move direction, border walls keep it in range
  always_comb begin
    step_tgt.floor = status.floor;
    step_tgt.x     = status.x;
    step_tgt.y     = status.y;
    case (dir)
      UP:      step_tgt.y = status.y - 4'd1;
      DOWN:    step_tgt.y = status.y + 4'd1;
      LEFT:    step_tgt.x = status.x - 4'd1;
      default: step_tgt.x = status.x + 4'd1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && move) begin
      tgt <= step_tgt;
    end
  end

  // interaction rules on the tile read back
  always_comb begin
    tile        = map.rdata;
    next_status = status;
    step        = 1'b0;
    consume     = 1'b0;
    case (tile.obj.kind)
      EMPTY: begin
        step = 1'b1;
      end
      KEY: begin
        step                = 1'b1;
        consume             = 1'b1;
        next_status.key_num = status.key_num + 4'd1;
      end
      DOOR: begin
        if (status.key_num != 4'd0) begin
          step                = 1'b1;
          consume             = 1'b1;
          next_status.key_num = status.key_num - 4'd1;
        end
      end
      MONSTER: begin
        // only a fight the player survives
        if (status.health > 16'(tile.obj.value)) begin
          step               = 1'b1;
          consume            = 1'b1;
          next_status.health = status.health - 16'(tile.obj.value);
        end
      end
      STAIRS: begin
        if (status.floor != 2'(`FLOORS - 1)) begin
          next_status.floor = status.floor + 2'd1;
        end
        next_status.x = 4'd1;
        next_status.y = 4'd1;
      end
      default: begin
      end
    endcase
    if (step) begin
      next_status.x = tgt.x;
      next_status.y = tgt.y;
    end
  end

  assign map.addr = tgt;
  assign map.wr   = (state == S_EVAL) && consume;

  // consumed tiles become empty
  always_comb begin
    map.wdata          = '0;
    map.wdata.obj.kind = EMPTY;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= S_IDLE;
      status.floor   <= 2'd0;
      status.x       <= 4'd1;
      status.y       <= 4'd1;
      status.key_num <= 4'd0;
      status.health  <= 16'(`START_HEALTH);
    end else begin
      case (state)
        S_IDLE: begin
          if (move) begin
            state <= S_READ;
          end
        end
        S_READ: begin
          state <= S_EVAL;
        end
        default: begin
          status <= next_status;
          state  <= S_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/player_pkg.sv
`default_nettype none

package player_pkg;

  typedef enum logic [1:0] {
    UP,
    DOWN,
    LEFT,
    RIGHT
  } dir_e;

  typedef struct packed {
    logic [1:0]  floor;
    logic [3:0]  x;
    logic [3:0]  y;
    logic [3:0]  key_num;
    logic [15:0] health;
  } player_status_s;

endpackage

`default_nettype wire

// File: source/tile_pkg.sv
`default_nettype none

package tile_pkg;

  typedef enum logic [3:0] {
    EMPTY   = 4'd0,
    WALL    = 4'd1,
    KEY     = 4'd2,
    DOOR    = 4'd3,
    MONSTER = 4'd4,
    STAIRS  = 4'd5
  } tile_kind_e;

  // game logic view, value is the monster damage
  typedef struct packed {
    tile_kind_e  kind;
    logic [11:0] value;
  } tile_obj_s;

  // graphics view
  typedef struct packed {
    logic [7:0] sprite;
    logic [7:0] palette;
  } tile_gfx_s;

  typedef union packed {
    tile_obj_s obj;
    tile_gfx_s gfx;
  } tile_word_u;

  typedef struct packed {
    logic [1:0] floor;
    logic [3:0] y;
    logic [3:0] x;
  } map_addr_t;

endpackage

`default_nettype wire

// File: tb/tb_game_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_macros.svh"

module tb_game_core;
  import tile_pkg::*;
  import player_pkg::*;

  localparam int N_SCRIPT = 64;
  localparam int N_RAND = 300;
  localparam int N_FRAMES = 2;
  // a long hold takes about two press slots
  localparam int TIMEOUT_NS = ((N_SCRIPT + 2 * N_RAND) * 24 + N_FRAMES * 300 + 100) * 40;

  logic        clk;
  logic        rst;
  logic [3:0]  keys;
  logic        frame_start;
  logic [1:0]  floor;
  logic [3:0]  player_x;
  logic [3:0]  player_y;
  logic [3:0]  key_num;
  logic [15:0] health;
  logic [7:0]  dst_addr;
  logic [15:0] dst_data;
  logic        dst_wr;
  logic        frame_done;

  // model state
  logic [15:0] model_map [`FLOORS * `MAP_DIM * `MAP_DIM];
  int          m_floor;
  int          m_x;
  int          m_y;
  int          m_keys;
  int          m_health;
  logic        lethal_seen;
  int          errors;
  logic [31:0] lcg_state;

  game_core i_game_core (
    .clk         (clk),
    .rst         (rst),
    .keys        (keys),
    .frame_start (frame_start),
    .floor       (floor),
    .player_x    (player_x),
    .player_y    (player_y),
    .key_num     (key_num),
    .health      (health),
    .dst_addr    (dst_addr),
    .dst_data    (dst_data),
    .dst_wr      (dst_wr),
    .frame_done  (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  initial begin
    #(TIMEOUT_NS * 1ns);
    abort_run("timeout, the test sequence did not finish in time");
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: expected 0x%0h, observed 0x%0h", name, exp, got);
      abort_run("value mismatch");
    end
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // level design with one word per tile
  function automatic logic [15:0] level_word(input int f, input int x, input int y);
    if (x == 0 || y == 0 || x == 15 || y == 15) return {WALL, 12'd0};
    if (x == 8) return (y == 8) ? {DOOR, 12'd0} : {WALL, 12'd0};
    if (x == 2 * f + 3 && y == 2) return {KEY, 12'd0};
    if (x == 4 && y == 4 + f) return {MONSTER, 12'(10 + f)};
    if (x == 14 && y == 14) return {STAIRS, 12'd0};
    return 16'h0000;
  endfunction

  function automatic logic [3:0] key_mask(input dir_e d);
    // keys is {right, up, down, left}
    case (d)
      UP:      return 4'b0100;
      DOWN:    return 4'b0010;
      LEFT:    return 4'b0001;
      default: return 4'b1000;
    endcase
  endfunction

  task automatic apply_model(input dir_e d);
    int          tx;
    int          ty;
    int          idx;
    logic [15:0] w;
    tx = m_x;
    ty = m_y;
    case (d)
      UP:      ty = ty - 1;
      DOWN:    ty = ty + 1;
      LEFT:    tx = tx - 1;
      default: tx = tx + 1;
    endcase
    idx = (m_floor * 16 + ty) * 16 + tx;
    w = model_map[idx];
    case (w[15:12])
      EMPTY: begin
        m_x = tx;
        m_y = ty;
      end
      KEY: begin
        m_keys++;
        model_map[idx] = 16'h0000;
        m_x = tx;
        m_y = ty;
      end
      DOOR: begin
        if (m_keys != 0) begin
          m_keys--;
          model_map[idx] = 16'h0000;
          m_x = tx;
          m_y = ty;
        end
      end
      MONSTER: begin
        if (m_health > int'(w[11:0])) begin
          m_health = m_health - int'(w[11:0]);
          model_map[idx] = 16'h0000;
          m_x = tx;
          m_y = ty;
        end else begin
          lethal_seen = 1'b1;
        end
      end
      STAIRS: begin
        if (m_floor < `FLOORS - 1) m_floor++;
        m_x = 1;
        m_y = 1;
      end
      default: begin
      end
    endcase
  endtask

  task automatic check_status();
    check_value("floor", floor, m_floor);
    check_value("player_x", player_x, m_x);
    check_value("player_y", player_y, m_y);
    check_value("key_num", key_num, m_keys);
    check_value("health", health, m_health);
  endtask

  // status settles within TICK_DIV+4 cycles of the key rise
  task automatic press_key(input dir_e d, input int hold);
    apply_model(d);
    keys = key_mask(d);
    repeat (`TICK_DIV + 4) @(posedge clk);
    #2;
    check_status();
    repeat (hold - (`TICK_DIV + 4)) @(posedge clk);
    #2;
    keys = 4'b0000;
    repeat (12) @(posedge clk);
    #2;
    check_status();
  endtask

  task automatic walk(input dir_e d, input int n);
    repeat (n) press_key(d, 12);
  endtask

  task automatic render_frame();
    int          waited;
    logic [15:0] exp_data;
    waited = 1;
    frame_start = 1'b1;
    @(posedge clk);
    #2;
    frame_start = 1'b0;
    while (dst_wr !== 1'b1) begin
      if (waited >= 10) abort_run("no frame buffer write after frame_start");
      @(posedge clk);
      #2;
      waited++;
    end
    check_value("first write latency", waited, 2);
    for (int i = 0; i < 256; i++) begin
      exp_data = model_map[m_floor * 256 + i];
      if (i == m_y * 16 + m_x) exp_data[15:8] = `PLAYER_SPRITE;
      check_value("dst_wr", dst_wr, 1);
      check_value("dst_addr", dst_addr, i);
      check_value("dst_data", dst_data, exp_data);
      check_value("frame_done", frame_done, i == 255);
      // restarts during the frame must be ignored
      frame_start = (i == 10 || i == 255);
      @(posedge clk);
      #2;
      frame_start = 1'b0;
    end
    repeat (20) begin
      check_value("dst_wr", dst_wr, 0);
      check_value("frame_done", frame_done, 0);
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    logic [31:0] r;
    errors = 0;
    lethal_seen = 1'b0;
    lcg_state = 32'd64;
    keys = 4'b0000;
    frame_start = 1'b0;
    rst = 1'b1;
    for (int f = 0; f < `FLOORS; f++)
      for (int y = 0; y < `MAP_DIM; y++)
        for (int x = 0; x < `MAP_DIM; x++)
          model_map[(f * 16 + y) * 16 + x] = level_word(f, x, y);
    m_floor = 0;
    m_x = 1;
    m_y = 1;
    m_keys = 0;
    m_health = `START_HEALTH;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    repeat (10) begin
      check_status();
      check_value("dst_wr", dst_wr, 0);
      check_value("frame_done", frame_done, 0);
      @(posedge clk);
      #2;
    end

    // wall, door without a key, key, monster, door, stairs
    walk(UP, 1);
    walk(DOWN, 7);
    walk(RIGHT, 6);
    walk(RIGHT, 1);
    walk(UP, 6);
    walk(LEFT, 4);
    walk(DOWN, 2);
    walk(RIGHT, 1);
    walk(DOWN, 4);
    walk(RIGHT, 3);
    press_key(RIGHT, 40);
    walk(RIGHT, 6);
    walk(DOWN, 6);
    check_value("floor", floor, 1);
    check_value("health", health, `START_HEALTH - 10);
    render_frame();

    for (int n = 0; n < N_RAND; n++) begin
      r = next_rand();
      press_key(dir_e'(r[17:16]), (r[27:25] == 3'd0) ? 40 : 12);
    end
    if (!lethal_seen) begin
      $display("note: no lethal monster fight was reached, that check is skipped");
    end
    render_frame();

    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/tile_pkg.sv
source/player_pkg.sv
source/map_port_if.sv
source/move_arbiter.sv
source/player_ctrl.sv
source/map_ram.sv
source/map_renderer.sv
source/game_core.sv
tb/tb_game_core.sv
